// File: logic/game_pkg.sv
package game_pkg;

    // level numbers shown in the menu
    typedef logic [2:0] level_t;

    localparam level_t LEVEL_MIN = 3'd1;
    localparam level_t LEVEL_MAX = 3'd5;

    // movement encodings kept from the sprite logic
    typedef enum logic [3:0] {
        move_stand = 4'd6,
        move_right = 4'd7,
        move_left  = 4'd8,
        move_up    = 4'd9
    } move_e;

    typedef enum logic [1:0] {
        jump_idle = 2'd0,
        jump_rise = 2'd1,
        jump_fall = 2'd2
    } jump_e;

    typedef logic [7:0] jump_cnt_t;

    localparam jump_cnt_t JUMP_RISE_STEPS  = 8'd70;
    localparam jump_cnt_t JUMP_TOTAL_STEPS = 8'd240;

    typedef struct packed {
        logic up;
        logic left;
        logic down;
        logic right;
    } dir_keys_t;

    // per-player feedback from the level renderer
    typedef struct packed {
        logic collision;
        logic land;
        logic should_down;
    } world_fb_t;

    typedef struct packed {
        move_e move;
        jump_e jump;
    } player_status_t;

    // bit positions in key_down
    localparam int KEY_P2_UP    = 0;
    localparam int KEY_P2_LEFT  = 1;
    localparam int KEY_P2_DOWN  = 2;
    localparam int KEY_P2_RIGHT = 3;
    localparam int KEY_P1_UP    = 4;
    localparam int KEY_P1_LEFT  = 5;
    localparam int KEY_P1_DOWN  = 6;
    localparam int KEY_P1_RIGHT = 7;
    localparam int KEY_CONFIRM  = 8;

    // menu sheet geometry, in half-resolution pixels
    localparam int ROW_STRIDE  = 320;
    localparam int ICON_X0     = 150;
    localparam int ICON_X_WIDE = 148;
    localparam int ICON_X_END  = 170;
    localparam int SEL_SHEET_X = 127;
    localparam int ROW_Y0      = 40;
    localparam int ROW_PITCH   = 40;
    localparam int ROW_H       = 25;
    localparam int ROWS        = 5;

    typedef logic [16:0] pixel_addr_t;

endpackage

// File: logic/level_menu.sv
module level_menu (
    input  logic             clk,
    input  logic             rst,
    input  logic [9:0]       key_down,
    output game_pkg::level_t level,
    output logic             playing
);
    import game_pkg::*;

    logic locked;
    logic key_inc;
    logic key_dec;
    logic any_key;

    // either player's up/down keys step the level
    assign key_inc = key_down[KEY_P1_UP] | key_down[KEY_P2_UP];
    assign key_dec = key_down[KEY_P1_DOWN] | key_down[KEY_P2_DOWN];
    assign any_key = |key_down;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            level   <= LEVEL_MIN;
            playing <= 1'b0;
            locked  <= 1'b0;
        end else if (!playing) begin
            if (!any_key) begin
                // all keys released, accept the next press
                locked <= 1'b0;
            end else if (!locked) begin
                if (key_inc) begin
                    if (level < LEVEL_MAX) begin
                        level <= level + 3'd1;
                    end
                    locked <= 1'b1;
                end else if (key_dec) begin
                    if (level > LEVEL_MIN) begin
                        level <= level - 3'd1;
                    end
                    locked <= 1'b1;
                end else if (key_down[KEY_CONFIRM]) begin
                    playing <= 1'b1;
                end
            end
        end
    end

    // no return to the menu, so the chosen level must stay in range forever
    level_in_range: assert property (
        @(posedge clk) disable iff (rst)
        level >= LEVEL_MIN && level <= LEVEL_MAX
    );

endmodule

// File: logic/player_ctrl.sv
module player_ctrl (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     enable,
    input  game_pkg::dir_keys_t      keys,
    input  game_pkg::world_fb_t      fb,
    output game_pkg::player_status_t status
);
    import game_pkg::*;

    move_e     move_q;
    move_e     move_d;
    jump_e     jump_q;
    jump_e     jump_d;
    jump_cnt_t cnt_q;
    jump_cnt_t cnt_d;
    jump_e     step_jump;
    jump_cnt_t step_cnt;
    jump_e     fall_jump;
    jump_cnt_t fall_cnt;
    logic      no_keys;
    logic      only_up;
    logic      go_left;
    logic      go_right;

    assign no_keys  = !keys.up && !keys.left && !keys.down && !keys.right;
    assign only_up  = keys.up && !keys.left && !keys.down && !keys.right;
    assign go_left  = keys.left && !keys.right;
    assign go_right = keys.right && !keys.left;

    // fall step alone counts on until landing or the jump limit
    always_comb begin
        if (cnt_q < JUMP_TOTAL_STEPS && !fb.land) begin
            fall_jump = jump_fall;
            fall_cnt  = cnt_q + 8'd1;
        end else begin
            fall_jump = jump_idle;
            fall_cnt  = '0;
        end
    end

    // full jump step rises until the limit or a ceiling hit
    always_comb begin
        if (cnt_q < JUMP_RISE_STEPS && !fb.collision && jump_q != jump_fall) begin
            step_jump = jump_rise;
            step_cnt  = cnt_q + 8'd1;
        end else begin
            step_jump = fall_jump;
            step_cnt  = fall_cnt;
        end
    end

    always_comb begin
        move_d = move_q;
        jump_d = jump_q;
        cnt_d  = cnt_q;
        if (!enable) begin
            move_d = move_stand;
            jump_d = jump_idle;
            cnt_d  = '0;
        end else if (no_keys) begin
            if (jump_q == jump_idle) begin
                move_d = move_stand;
                cnt_d  = '0;
            end else begin
                jump_d = step_jump;
                cnt_d  = step_cnt;
            end
        end else if (only_up) begin
            move_d = move_up;
            jump_d = step_jump;
            cnt_d  = step_cnt;
        end else if (go_left || go_right) begin
            move_d = go_left ? move_left : move_right;
            if ((keys.up || jump_q != jump_idle) && !fb.should_down) begin
                jump_d = step_jump;
                cnt_d  = step_cnt;
            end else if (fb.should_down) begin
                // walked off a ledge
                jump_d = fall_jump;
                cnt_d  = fall_cnt;
            end else begin
                jump_d = jump_idle;
            end
        end else if (jump_q != jump_idle) begin
            jump_d = step_jump;
            cnt_d  = step_cnt;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            move_q <= move_stand;
            jump_q <= jump_idle;
            cnt_q  <= '0;
        end else begin
            move_q <= move_d;
            jump_q <= jump_d;
            cnt_q  <= cnt_d;
        end
    end

    assign status = '{move: move_q, jump: jump_q};

    cnt_bounded: assert property (
        @(posedge clk) disable iff (rst)
        cnt_q <= JUMP_TOTAL_STEPS
    );

    // once the rise limit is reached the next phase can no longer be rise
    rise_ends: assert property (
        @(posedge clk) disable iff (rst)
        cnt_q >= JUMP_RISE_STEPS |=> jump_q != jump_rise
    );

endmodule

// File: logic/menu_pixel_addr.sv
module menu_pixel_addr (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  playing,
    input  game_pkg::level_t      level,
    input  logic [9:0]            vga_h,
    input  logic [9:0]            vga_v,
    output game_pkg::pixel_addr_t pixel_addr
);
    import game_pkg::*;

    // beam position at half resolution
    logic [8:0]  h;
    logic [8:0]  v;
    pixel_addr_t addr_d;

    assign h = vga_h[9:1];
    assign v = vga_v[9:1];

    always_comb begin
        int sel_row;
        int top;
        int x_start;
        int x_base;
        addr_d  = '0;
        sel_row = int'(level) - 1;
        for (int i = 0; i < ROWS; i++) begin
            top = ROW_Y0 + i * ROW_PITCH;
            // selected level is drawn two pixels wider from another sheet column
            x_start = (i == sel_row) ? ICON_X_WIDE : ICON_X0;
            x_base  = (i == sel_row) ? SEL_SHEET_X : ICON_X0;
            if (int'(v) >= top && int'(v) < top + ROW_H &&
                int'(h) >= x_start && int'(h) < ICON_X_END) begin
                addr_d = pixel_addr_t'((int'(h) - x_base) + (int'(v) - top + 1) * ROW_STRIDE);
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pixel_addr <= '0;
        end else if (playing) begin
            // no level renderer, play screen reads address zero
            pixel_addr <= '0;
        end else begin
            pixel_addr <= addr_d;
        end
    end

endmodule

// File: logic/game_ctrl_top.sv
module game_ctrl_top (
    input  logic                     clk,
    input  logic                     rst,
    input  logic [9:0]               key_down,
    input  logic [9:0]               vga_h,
    input  logic [9:0]               vga_v,
    input  game_pkg::world_fb_t      p1_fb,
    input  game_pkg::world_fb_t      p2_fb,
    output game_pkg::level_t         level,
    output logic                     playing,
    output game_pkg::player_status_t p1_status,
    output game_pkg::player_status_t p2_status,
    output game_pkg::pixel_addr_t    pixel_addr
);
    import game_pkg::*;

    dir_keys_t p1_keys;
    dir_keys_t p2_keys;

    // p1 sits on the upper nibble, p2 on the lower one
    assign p1_keys = '{up: key_down[KEY_P1_UP], left: key_down[KEY_P1_LEFT],
                       down: key_down[KEY_P1_DOWN], right: key_down[KEY_P1_RIGHT]};
    assign p2_keys = '{up: key_down[KEY_P2_UP], left: key_down[KEY_P2_LEFT],
                       down: key_down[KEY_P2_DOWN], right: key_down[KEY_P2_RIGHT]};

    level_menu menu (
        .clk      (clk),
        .rst      (rst),
        .key_down (key_down),
        .level    (level),
        .playing  (playing)
    );

    player_ctrl p1_ctrl (
        .clk    (clk),
        .rst    (rst),
        .enable (playing),
        .keys   (p1_keys),
        .fb     (p1_fb),
        .status (p1_status)
    );

    player_ctrl p2_ctrl (
        .clk    (clk),
        .rst    (rst),
        .enable (playing),
        .keys   (p2_keys),
        .fb     (p2_fb),
        .status (p2_status)
    );

    menu_pixel_addr menu_addr (
        .clk        (clk),
        .rst        (rst),
        .playing    (playing),
        .level      (level),
        .vga_h      (vga_h),
        .vga_v      (vga_v),
        .pixel_addr (pixel_addr)
    );

endmodule

// File: tb/tb_clock.sv
module tb_clock (
    output logic clk,
    output logic rst
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam int HALF_PERIOD  = 2;
    localparam int RESET_CYCLES = 3;

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    // release in step with the stimulus, just after an edge
    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0;
    end

endmodule

// File: tb/game_checker.sv
module game_checker (
    input  logic                     clk,
    input  logic                     rst,
    input  logic [9:0]               key_down,
    input  logic [9:0]               vga_h,
    input  logic [9:0]               vga_v,
    input  game_pkg::world_fb_t      p1_fb,
    input  game_pkg::world_fb_t      p2_fb,
    input  game_pkg::level_t         level,
    input  logic                     playing,
    input  game_pkg::player_status_t p1_status,
    input  game_pkg::player_status_t p2_status,
    input  game_pkg::pixel_addr_t    pixel_addr,
    output int                       errors
);
    timeunit 1ns;
    timeprecision 100ps;
    import game_pkg::*;

    typedef struct packed {
        move_e     move;
        jump_e     jump;
        jump_cnt_t cnt;
    } player_model_t;

    level_t        exp_level;
    logic          exp_playing;
    logic          exp_locked;
    player_model_t exp_p1;
    player_model_t exp_p2;
    pixel_addr_t   exp_addr;

    initial begin
        errors = 0;
    end

    // sheet address of one beam position on the menu screen
    function automatic pixel_addr_t menu_address(level_t lvl, logic [9:0] bh, logic [9:0] bv);
        int h;
        int v;
        int top;
        int addr;
        h    = int'(bh) / 2;
        v    = int'(bv) / 2;
        addr = 0;
        for (int i = 0; i < ROWS; i++) begin
            top = ROW_Y0 + i * ROW_PITCH;
            if (v >= top && v < top + ROW_H) begin
                if (i == int'(lvl) - 1) begin
                    if (h >= ICON_X_WIDE && h < ICON_X_END)
                        addr = (h - SEL_SHEET_X) + (v - top + 1) * ROW_STRIDE;
                end else if (h >= ICON_X0 && h < ICON_X_END) begin
                    addr = (h - ICON_X0) + (v - top + 1) * ROW_STRIDE;
                end
            end
        end
        return pixel_addr_t'(addr);
    endfunction

    function automatic player_model_t player_next(player_model_t s, dir_keys_t k,
                                                  world_fb_t f, logic en);
        player_model_t fall;
        player_model_t jstep;
        player_model_t n;
        // second half of a jump step on its own
        fall = s;
        if (s.cnt < JUMP_TOTAL_STEPS && !f.land) begin
            fall.jump = jump_fall;
            fall.cnt  = s.cnt + 8'd1;
        end else begin
            fall.jump = jump_idle;
            fall.cnt  = '0;
        end
        jstep = fall;
        if (s.cnt < JUMP_RISE_STEPS && !f.collision && s.jump != jump_fall) begin
            jstep.jump = jump_rise;
            jstep.cnt  = s.cnt + 8'd1;
        end
        n = s;
        if (!en) begin
            n = '{move: move_stand, jump: jump_idle, cnt: '0};
        end else if (k == 4'b0000) begin
            if (s.jump == jump_idle) begin
                n.move = move_stand;
                n.cnt  = '0;
            end else begin
                n = jstep;
            end
        end else if (k == 4'b1000) begin
            n      = jstep;
            n.move = move_up;
        end else if (k.left != k.right) begin
            n.move = k.left ? move_left : move_right;
            if ((k.up || s.jump != jump_idle) && !f.should_down) begin
                n.jump = jstep.jump;
                n.cnt  = jstep.cnt;
            end else if (f.should_down) begin
                n.jump = fall.jump;
                n.cnt  = fall.cnt;
            end else begin
                n.jump = jump_idle;
            end
        end else if (s.jump != jump_idle) begin
            n = jstep;
        end
        return n;
    endfunction

    always @(posedge clk or posedge rst) begin
        if (rst) begin
            exp_level   <= LEVEL_MIN;
            exp_playing <= 1'b0;
            exp_locked  <= 1'b0;
            exp_p1      <= '{move: move_stand, jump: jump_idle, cnt: '0};
            exp_p2      <= '{move: move_stand, jump: jump_idle, cnt: '0};
            exp_addr    <= '0;
        end else begin
            exp_addr <= exp_playing ? '0 : menu_address(exp_level, vga_h, vga_v);
            exp_p1 <= player_next(exp_p1, {key_down[KEY_P1_UP], key_down[KEY_P1_LEFT],
                                  key_down[KEY_P1_DOWN], key_down[KEY_P1_RIGHT]},
                                  p1_fb, exp_playing);
            exp_p2 <= player_next(exp_p2, {key_down[KEY_P2_UP], key_down[KEY_P2_LEFT],
                                  key_down[KEY_P2_DOWN], key_down[KEY_P2_RIGHT]},
                                  p2_fb, exp_playing);
            // menu steps once per press, lock clears with every key up
            if (!exp_playing) begin
                if (key_down == '0) begin
                    exp_locked <= 1'b0;
                end else if (!exp_locked) begin
                    if (key_down[KEY_P1_UP] || key_down[KEY_P2_UP]) begin
                        if (exp_level != LEVEL_MAX) exp_level <= exp_level + 3'd1;
                        exp_locked <= 1'b1;
                    end else if (key_down[KEY_P1_DOWN] || key_down[KEY_P2_DOWN]) begin
                        if (exp_level != LEVEL_MIN) exp_level <= exp_level - 3'd1;
                        exp_locked <= 1'b1;
                    end else if (key_down[KEY_CONFIRM]) begin
                        exp_playing <= 1'b1;
                    end
                end
            end
        end
    end

    task automatic compare_value(string name, logic [31:0] expected, logic [31:0] actual);
        if (expected !== actual) begin
            errors++;
            $display("Fail %s expected %h actual %h at %0t", name, expected, actual, $time);
        end
    endtask

    // outputs settle well before the falling edge
    always @(negedge clk) begin
        compare_value("level", 32'(exp_level), 32'(level));
        compare_value("playing", 32'(exp_playing), 32'(playing));
        compare_value("p1_status", 32'({exp_p1.move, exp_p1.jump}), 32'(p1_status));
        compare_value("p2_status", 32'({exp_p2.move, exp_p2.jump}), 32'(p2_status));
        compare_value("pixel_addr", 32'(exp_addr), 32'(pixel_addr));
    end

endmodule

// File: tb/tb_top.sv
module tb_top;
    timeunit 1ns;
    timeprecision 100ps;
    import game_pkg::*;

    localparam int CLK_PERIOD    = 4;
    localparam int RESET_CYCLES  = 3;
    localparam int SETTLE_CYCLES = 2;
    localparam int RESET_TEST    = 8;
    localparam int NAV_CYCLES    = 400;
    localparam int ADDR_CYCLES   = 600;
    localparam int ENTRY_CYCLES  = 120;
    localparam int MOVE_CYCLES   = 4000;
    localparam int TOTAL_CYCLES  = RESET_CYCLES + RESET_TEST + NAV_CYCLES + ADDR_CYCLES
                                 + ENTRY_CYCLES + MOVE_CYCLES + 5 * SETTLE_CYCLES;
    localparam int LIMIT_CYCLES  = TOTAL_CYCLES + TOTAL_CYCLES / 5;

    logic           clk;
    logic           rst;
    logic [9:0]     key_down;
    logic [9:0]     vga_h;
    logic [9:0]     vga_v;
    world_fb_t      p1_fb;
    world_fb_t      p2_fb;
    level_t         level;
    logic           playing;
    player_status_t p1_status;
    player_status_t p2_status;
    pixel_addr_t    pixel_addr;
    int             errors;
    int             tests_passed;
    int             tests_failed;
    int             errors_at_start;
    int             key_hold;
    int             fb_hold;

    tb_clock clock_gen (.clk(clk), .rst(rst));

    game_ctrl_top dut0 (
        .clk(clk), .rst(rst), .key_down(key_down), .vga_h(vga_h), .vga_v(vga_v),
        .p1_fb(p1_fb), .p2_fb(p2_fb), .level(level), .playing(playing),
        .p1_status(p1_status), .p2_status(p2_status), .pixel_addr(pixel_addr)
    );

    game_checker checker0 (
        .clk(clk), .rst(rst), .key_down(key_down), .vga_h(vga_h), .vga_v(vga_v),
        .p1_fb(p1_fb), .p2_fb(p2_fb), .level(level), .playing(playing),
        .p1_status(p1_status), .p2_status(p2_status), .pixel_addr(pixel_addr),
        .errors(errors)
    );

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    // 0 and 6 release every key, 5 holds a key that never steps the level
    function automatic logic [9:0] menu_key(int sel);
        case (sel)
            1: return 10'd1 << KEY_P2_UP;
            2: return 10'd1 << KEY_P2_DOWN;
            3: return 10'd1 << KEY_P1_UP;
            4: return 10'd1 << KEY_P1_DOWN;
            5: return 10'd1 << KEY_P1_LEFT;
            default: return '0;
        endcase
    endfunction

    // mostly near the icon rows and the wide column edge
    task automatic drive_random_beam();
        int row;
        int h;
        int v;
        if ($urandom_range(3, 0) != 0) begin
            row = int'($urandom_range(ROWS - 1, 0));
            v   = ROW_Y0 + row * ROW_PITCH + int'($urandom_range(ROW_H + 3, 0)) - 2;
            if ($urandom_range(1, 0) == 0) h = ICON_X_WIDE - 2 + int'($urandom_range(5, 0));
            else h = ICON_X_WIDE - 2 + int'($urandom_range(25, 0));
            vga_h = 10'(h * 2 + int'($urandom_range(1, 0)));
            vga_v = 10'(v * 2 + int'($urandom_range(1, 0)));
        end else begin
            vga_h = 10'($urandom_range(639, 0));
            vga_v = 10'($urandom_range(479, 0));
        end
    endtask

    // landing kept rare so that some jumps run to the full length
    function automatic world_fb_t random_feedback();
        world_fb_t f;
        f.collision   = ($urandom_range(15, 0) == 0);
        f.land        = ($urandom_range(47, 0) == 0);
        f.should_down = ($urandom_range(7, 0) == 0);
        return f;
    endfunction

    task automatic end_test(string name);
        int new_errors;
        repeat (SETTLE_CYCLES) next_cycle();
        new_errors = errors - errors_at_start;
        if (new_errors == 0) begin
            tests_passed++;
            $display("test %s passed", name);
        end else begin
            tests_failed++;
            $display("test %s failed with %0d mismatches", name, new_errors);
        end
        errors_at_start = errors;
    endtask

    initial begin
        #(LIMIT_CYCLES * CLK_PERIOD);
        $display("run timed out, not finished after %0d cycles", LIMIT_CYCLES);
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        void'($urandom(32'h2c85_0712));
        tests_passed    = 0;
        tests_failed    = 0;
        errors_at_start = 0;
        key_down        = '0;
        vga_h           = '0;
        vga_v           = '0;
        p1_fb           = '0;
        p2_fb           = '0;
        @(negedge rst);

        repeat (RESET_TEST) next_cycle();
        end_test("reset values");

        key_hold = 0;
        for (int c = 0; c < NAV_CYCLES; c++) begin
            if (key_hold == 0) begin
                key_hold = int'($urandom_range(4, 1));
                key_down = menu_key(int'($urandom_range(6, 0)));
            end
            key_hold--;
            next_cycle();
        end
        end_test("menu navigation");

        for (int c = 0; c < ADDR_CYCLES; c++) begin
            drive_random_beam();
            key_down = (c % 8 == 0) ? menu_key(int'($urandom_range(4, 1))) : '0;
            next_cycle();
        end
        end_test("menu addresses");

        key_down = '0;
        next_cycle();
        key_down = 10'd1 << KEY_CONFIRM;
        next_cycle();
        key_down = '0;
        next_cycle();
        for (int c = 0; c < ENTRY_CYCLES - 3; c++) begin
            drive_random_beam();
            key_down = (c % 4 == 0) ? menu_key(int'($urandom_range(4, 1))) : '0;
            next_cycle();
        end
        end_test("entering play");

        key_hold = 0;
        fb_hold  = 0;
        for (int c = 0; c < MOVE_CYCLES; c++) begin
            if (key_hold == 0) begin
                key_hold = int'($urandom_range(8, 1));
                key_down = 10'($urandom_range(511, 0));
            end
            if (fb_hold == 0) begin
                fb_hold = int'($urandom_range(6, 1));
                p1_fb   = random_feedback();
                p2_fb   = random_feedback();
            end
            key_hold--;
            fb_hold--;
            drive_random_beam();
            next_cycle();
        end
        end_test("player movement and jumps");

        $display("tests passed %0d, failed %0d, mismatches %0d",
                 tests_passed, tests_failed, errors);
        if (tests_failed == 0 && errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: tb.f
logic/game_pkg.sv
logic/level_menu.sv
logic/player_ctrl.sv
logic/menu_pixel_addr.sv
logic/game_ctrl_top.sv
tb/tb_clock.sv
tb/game_checker.sv
tb/tb_top.sv

// File: run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert --timescale 1ns/100ps --top-module tb_top \
    -f tb.f -o tb_sim > build.log 2>&1 \
    && ./obj_dir/tb_sim > sim.log 2>&1 \
    || { cat build.log; echo "build or simulation stopped with an error"; }

[ -f sim.log ] && cat sim.log

grep -qx "TEST OK" sim.log 2>/dev/null && echo "simulation passed" && exit 0 \
    || { echo "simulation failed"; exit 1; }
